// ==== design/fp_compare.sv ====
`timescale 1ns/1ps

module fp_compare (
    input  pool_fp_pkg::fp_word_t a,
    input  pool_fp_pkg::fp_word_t b,
    output logic                  a_ge_b
);

    // magnitudes, exponent over mantissa
    pool_fp_pkg::fp_mag_t a_mag;
    pool_fp_pkg::fp_mag_t b_mag;
    logic                 both_zero;

    assign a_mag = {a.fields.exponent, a.fields.mantissa};
    assign b_mag = {b.fields.exponent, b.fields.mantissa};

    // +0 and -0 are the same value
    assign both_zero = (a_mag == '0) && (b_mag == '0);

    //////////////////////////////////////////////////
    // sign and magnitude ordering
    //////////////////////////////////////////////////

    always_comb begin
        if (both_zero) begin
            a_ge_b = 1'b1;
        end else if (a.fields.sign != b.fields.sign) begin
            // positive side wins
            a_ge_b = ~a.fields.sign;
        end else if (!a.fields.sign) begin
            // both positive, bigger magnitude is larger
            a_ge_b = (a_mag >= b_mag);
        end else begin
            // both negative, order flips
            a_ge_b = (a_mag <= b_mag);
        end
    end

endmodule

// ==== design/max_pool.sv ====
`timescale 1ns/1ps
`include "pool_params.svh"

module max_pool (
    input  logic                       clk,
    input  logic                       reset,
    input  pool_win_pkg::pool_window_t window,
    input  logic                       window_valid,
    output pool_fp_pkg::fp_word_t      pool_out,
    output logic                       pool_valid
);

    // odd one out of the pair tree
    localparam int last_idx = `POOL_WIN*`POOL_WIN - 1;

    // stage 1, four pair maxima
    logic [3:0]            s1_ge;
    pool_fp_pkg::fp_word_t s1_max [4];
    pool_fp_pkg::fp_word_t s1_last;
    logic                  s1_valid;

    // stage 2, two values left
    logic [1:0]            s2_ge;
    pool_fp_pkg::fp_word_t s2_max [2];
    pool_fp_pkg::fp_word_t s2_last;
    logic                  s2_valid;

    // stage 3, max of elements 0..7
    logic                  s3_ge;
    pool_fp_pkg::fp_word_t s3_max;
    pool_fp_pkg::fp_word_t s3_last;
    logic                  s3_valid;

    // stage 4, against element 8
    logic                  s4_ge;

    //////////////////////////////////////////////////
    // stage 1
    //////////////////////////////////////////////////

    // compares run straight off the incoming window
    for (genvar i = 0; i < 4; i++) begin : g_s1
        fp_compare u_cmp (
            .a      (window.px[2*i]),
            .b      (window.px[2*i + 1]),
            .a_ge_b (s1_ge[i])
        );
    end

    always_ff @(posedge clk) begin
        // ties keep the lower index
        for (int k = 0; k < 4; k++) begin
            s1_max[k] <= s1_ge[k] ? window.px[2*k] : window.px[2*k + 1];
        end
        s1_last <= window.px[last_idx];
    end

    //////////////////////////////////////////////////
    // stage 2
    //////////////////////////////////////////////////

    for (genvar i = 0; i < 2; i++) begin : g_s2
        fp_compare u_cmp (
            .a      (s1_max[2*i]),
            .b      (s1_max[2*i + 1]),
            .a_ge_b (s2_ge[i])
        );
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            s2_max[k] <= s2_ge[k] ? s1_max[2*k] : s1_max[2*k + 1];
        end
        s2_last <= s1_last;
    end

    //////////////////////////////////////////////////
    // stage 3
    //////////////////////////////////////////////////

    fp_compare u_cmp_s3 (
        .a      (s2_max[0]),
        .b      (s2_max[1]),
        .a_ge_b (s3_ge)
    );

    always_ff @(posedge clk) begin
        s3_max  <= s3_ge ? s2_max[0] : s2_max[1];
        s3_last <= s2_last;
    end

    //////////////////////////////////////////////////
    // stage 4
    //////////////////////////////////////////////////

    // elements 0..7 sit below 8, so they win a tie
    fp_compare u_cmp_s4 (
        .a      (s3_max),
        .b      (s3_last),
        .a_ge_b (s4_ge)
    );

    always_ff @(posedge clk) begin
        pool_out <= s4_ge ? s3_max : s3_last;
    end

    //////////////////////////////////////////////////
    // valid pipe
    //////////////////////////////////////////////////

    // free running, one bit per stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            s3_valid   <= 1'b0;
            pool_valid <= 1'b0;
        end else begin
            s1_valid   <= window_valid;
            s2_valid   <= s1_valid;
            s3_valid   <= s2_valid;
            pool_valid <= s3_valid;
        end
    end

endmodule

// ==== design/pool_fp_pkg.sv ====
`include "pool_params.svh"

package pool_fp_pkg;

    //////////////////////////////////////////////////
    // ieee-754 single precision layout
    //////////////////////////////////////////////////

    // msb first, sign then biased exponent then fraction
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp_fields_t;

    // datapath moves raw, the compare looks at fields
    typedef union packed {
        logic [`POOL_DATA_WIDTH-1:0] raw;
        fp_fields_t                  fields;
    } fp_word_t;

    // exponent and mantissa together, for magnitude order
    typedef logic [30:0] fp_mag_t;

endpackage

// ==== design/pool_params.svh ====
`ifndef POOL_PARAMS_SVH
`define POOL_PARAMS_SVH

//////////////////////////////////////////////////
// word format
//////////////////////////////////////////////////

// single precision float word
`define POOL_DATA_WIDTH 32

//////////////////////////////////////////////////
// map geometry
//////////////////////////////////////////////////

// feature map size in pixels
`define POOL_MAP_WIDTH  9
`define POOL_MAP_HEIGHT 9

// bits per row or column index
`define POOL_POS_WIDTH  4

//////////////////////////////////////////////////
// pooling window
//////////////////////////////////////////////////

// window side and step between windows
`define POOL_WIN        3
`define POOL_STRIDE     2

`endif

// ==== design/pool_top.sv ====
`timescale 1ns/1ps

module pool_top (
    input  logic                  clk,
    input  logic                  reset,
    input  pool_fp_pkg::fp_word_t pixel,
    input  logic                  pixel_valid,
    input  logic                  frame_start,
    output pool_fp_pkg::fp_word_t pool_out,
    output logic                  pool_valid
);

    // write and read column for the line buffer
    pool_win_pkg::map_pos_t     col;
    // pixels one and two rows above
    pool_fp_pkg::fp_word_t      row1_pixel;
    pool_fp_pkg::fp_word_t      row2_pixel;
    // finished window into the compare tree
    pool_win_pkg::pool_window_t window;
    logic                       window_valid;

    //////////////////////////////////////////////////
    // line buffer
    //////////////////////////////////////////////////

    row_line_buffer buffer (
        .clk         (clk),
        .reset       (reset),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .col         (col),
        .row1_pixel  (row1_pixel),
        .row2_pixel  (row2_pixel)
    );

    //////////////////////////////////////////////////
    // window builder
    //////////////////////////////////////////////////

    window_builder producer (
        .clk          (clk),
        .reset        (reset),
        .pixel        (pixel),
        .pixel_valid  (pixel_valid),
        .frame_start  (frame_start),
        .row1_pixel   (row1_pixel),
        .row2_pixel   (row2_pixel),
        .col          (col),
        .window       (window),
        .window_valid (window_valid)
    );

    //////////////////////////////////////////////////
    // max tree, 4 cycles
    //////////////////////////////////////////////////

    max_pool consumer (
        .clk          (clk),
        .reset        (reset),
        .window       (window),
        .window_valid (window_valid),
        .pool_out     (pool_out),
        .pool_valid   (pool_valid)
    );

endmodule

// ==== design/pool_win_pkg.sv ====
`include "pool_params.svh"

package pool_win_pkg;

    //////////////////////////////////////////////////
    // position in the map
    //////////////////////////////////////////////////

    // one row or column index
    typedef logic [`POOL_POS_WIDTH-1:0] pos_idx_t;

    // raster position of a pixel
    typedef struct packed {
        pos_idx_t row;
        pos_idx_t col;
    } map_pos_t;

    //////////////////////////////////////////////////
    // 3x3 window
    //////////////////////////////////////////////////

    // row major, px[0] top left, px[8] bottom right
    // px[2], px[5], px[8] form the newest column
    typedef struct packed {
        pool_fp_pkg::fp_word_t [`POOL_WIN*`POOL_WIN-1:0] px;
    } pool_window_t;

endpackage

// ==== design/row_line_buffer.sv ====
`timescale 1ns/1ps
`include "pool_params.svh"

module row_line_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  pool_fp_pkg::fp_word_t  pixel,
    input  logic                   pixel_valid,
    input  pool_win_pkg::map_pos_t col,
    output pool_fp_pkg::fp_word_t  row1_pixel,
    output pool_fp_pkg::fp_word_t  row2_pixel
);

    //////////////////////////////////////////////////
    // row storage
    //////////////////////////////////////////////////

    // row1 is the row just above, row2 the one above that
    pool_fp_pkg::fp_word_t row1_mem [`POOL_MAP_WIDTH];
    pool_fp_pkg::fp_word_t row2_mem [`POOL_MAP_WIDTH];

    // column being written this pixel
    pool_win_pkg::pos_idx_t wr_col;
    logic                   wr_en;

    assign wr_col = col.col;

    // pixels seen while in reset are dropped
    assign wr_en = pixel_valid && !reset;

    //////////////////////////////////////////////////
    // read before write
    //////////////////////////////////////////////////

    // old contents at this column, the write lands on the edge
    assign row1_pixel = row1_mem[wr_col];
    assign row2_pixel = row2_mem[wr_col];

    //////////////////////////////////////////////////
    // vertical shift per column
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            // row1 moves up into row2
            row2_mem[wr_col] <= row1_mem[wr_col];
            // new pixel becomes the row above
            row1_mem[wr_col] <= pixel;
        end
    end

endmodule

// ==== design/window_builder.sv ====
`timescale 1ns/1ps
`include "pool_params.svh"

module window_builder (
    input  logic                       clk,
    input  logic                       reset,
    input  pool_fp_pkg::fp_word_t      pixel,
    input  logic                       pixel_valid,
    input  logic                       frame_start,
    input  pool_fp_pkg::fp_word_t      row1_pixel,
    input  pool_fp_pkg::fp_word_t      row2_pixel,
    output pool_win_pkg::map_pos_t     col,
    output pool_win_pkg::pool_window_t window,
    output logic                       window_valid
);

    // last index on each axis
    localparam pool_win_pkg::pos_idx_t last_col = pool_win_pkg::pos_idx_t'(`POOL_MAP_WIDTH - 1);
    localparam pool_win_pkg::pos_idx_t last_row = pool_win_pkg::pos_idx_t'(`POOL_MAP_HEIGHT - 1);

    // first row and column that can close a window
    localparam pool_win_pkg::pos_idx_t first_end = pool_win_pkg::pos_idx_t'(`POOL_WIN - 1);

    // position expected for the next pixel
    pool_win_pkg::map_pos_t pos_q;
    // position of the pixel on the bus now
    pool_win_pkg::map_pos_t cur_pos;
    pool_win_pkg::map_pos_t next_pos;
    logic                   win_done;

    //////////////////////////////////////////////////
    // raster position
    //////////////////////////////////////////////////

    always_comb begin
        // frame_start pins this pixel to the origin
        cur_pos  = frame_start ? '0 : pos_q;
        next_pos = cur_pos;
        if (cur_pos.col == last_col) begin
            next_pos.col = '0;
            // wrap rows too so a missing frame_start recovers
            next_pos.row = (cur_pos.row == last_row) ? '0 : cur_pos.row + 1'b1;
        end else begin
            next_pos.col = cur_pos.col + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos_q <= '0;
        end else if (pixel_valid) begin
            pos_q <= next_pos;
        end
    end

    // line buffer addresses by the current column
    assign col = cur_pos;

    //////////////////////////////////////////////////
    // stride rule
    //////////////////////////////////////////////////

    // bottom right corner of a stride-2 window
    assign win_done = (cur_pos.row >= first_end) &&
                      (cur_pos.col >= first_end) &&
                      ((cur_pos.row % `POOL_STRIDE) == 0) &&
                      ((cur_pos.col % `POOL_STRIDE) == 0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            window_valid <= 1'b0;
        end else begin
            // one pulse, the cycle after the corner pixel
            window_valid <= pixel_valid && win_done;
        end
    end

    //////////////////////////////////////////////////
    // 3x3 shift window
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            // everything moves one column left
            for (int r = 0; r < `POOL_WIN; r++) begin
                for (int c = 0; c < `POOL_WIN - 1; c++) begin
                    window.px[r*`POOL_WIN + c] <= window.px[r*`POOL_WIN + c + 1];
                end
            end
            // new right column, oldest row on top
            window.px[`POOL_WIN - 1]           <= row2_pixel;
            window.px[2*`POOL_WIN - 1]         <= row1_pixel;
            window.px[`POOL_WIN*`POOL_WIN - 1] <= pixel;
        end
    end

endmodule

// ==== sim.f ====
+incdir+design
design/pool_fp_pkg.sv
design/pool_win_pkg.sv
design/fp_compare.sv
design/row_line_buffer.sv
design/window_builder.sv
design/max_pool.sv
design/pool_top.sv
tb/pool_assert.sv
tb/pool_tb.sv

// ==== tb/pool_assert.sv ====
`timescale 1ns/1ps

module pool_assert (
    input logic                  clk,
    input logic                  reset,
    input logic                  window_valid,
    input logic                  pool_valid,
    input pool_fp_pkg::fp_word_t pool_out
);

    // number of failed properties so far
    int fail_count = 0;

    //////////////////////////////////////////////////
    // top level timing
    //////////////////////////////////////////////////

    // no result pulse while reset holds
    a_quiet_in_reset: assert property (@(posedge clk) reset |-> (pool_valid !== 1'b1))
        else begin
            fail_count++;
            $error("pool_valid high while reset is high");
        end

    // tree latency is exactly four cycles
    a_tree_latency: assert property (@(posedge clk) disable iff (reset)
        window_valid |-> ##4 pool_valid)
        else begin
            fail_count++;
            $error("window_valid not followed by pool_valid 4 cycles later");
        end

    // result word fully known when strobed
    a_out_known: assert property (@(posedge clk) disable iff (reset)
        pool_valid |-> !$isunknown(pool_out))
        else begin
            fail_count++;
            $error("pool_out has unknown bits while pool_valid is high");
        end

endmodule

// ==== tb/pool_tb.sv ====
`timescale 1ns/1ps
`include "pool_params.svh"

module pool_tb;

    localparam int map_w          = `POOL_MAP_WIDTH;
    localparam int map_h          = `POOL_MAP_HEIGHT;
    localparam int frame_pixels   = map_w * map_h;
    localparam int drive_delay    = 5;
    localparam int reset_cycles   = 10;
    localparam int num_tests      = 6;
    // one pixel plus up to three idle cycles
    localparam int max_pixel_cyc  = 4;
    localparam int watchdog_cycles = num_tests * 100 * max_pixel_cyc + 50;
    localparam int drain_limit    = 20;
    localparam int extra_cycles   = 6;
    // one row and a few pixels, no window closes
    localparam int partial_pixels = map_w + 4;

    logic                  clk = 1'b0;
    logic                  reset;
    pool_fp_pkg::fp_word_t pixel;
    logic                  pixel_valid;
    logic                  frame_start;
    pool_fp_pkg::fp_word_t pool_out;
    logic                  pool_valid;

    // frame being sent, raster order
    pool_fp_pkg::fp_word_t frame [frame_pixels];
    // expected and received results
    pool_fp_pkg::fp_word_t exp_q [$];
    pool_fp_pkg::fp_word_t got_q [$];

    int          err_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          total_errs;
    logic [31:0] lfsr_state = 32'hfdde0e90;

    pool_top dut (
        .clk         (clk),
        .reset       (reset),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .frame_start (frame_start),
        .pool_out    (pool_out),
        .pool_valid  (pool_valid)
    );

    bind pool_top pool_assert u_assert (
        .clk          (clk),
        .reset        (reset),
        .window_valid (window_valid),
        .pool_valid   (pool_valid),
        .pool_out     (pool_out)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // random source
    //////////////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // monotonic key, zeros of both signs share one key
    function automatic logic [31:0] order_key(input pool_fp_pkg::fp_word_t w);
        logic [30:0] mag;
        mag = w.raw[30:0];
        if (mag == '0) begin
            return {1'b1, 31'd0};
        end else if (w.raw[31]) begin
            return {1'b0, ~mag};
        end
        return {1'b1, mag};
    endfunction

    // strict compare keeps the lower index on ties
    function automatic void build_expected();
        pool_fp_pkg::fp_word_t best;
        pool_fp_pkg::fp_word_t cand;
        for (int wr = 0; wr + `POOL_WIN <= map_h; wr += `POOL_STRIDE) begin
            for (int wc = 0; wc + `POOL_WIN <= map_w; wc += `POOL_STRIDE) begin
                best = frame[wr * map_w + wc];
                for (int k = 1; k < `POOL_WIN * `POOL_WIN; k++) begin
                    cand = frame[(wr + k / `POOL_WIN) * map_w + wc + k % `POOL_WIN];
                    if (order_key(cand) > order_key(best)) begin
                        best = cand;
                    end
                end
                exp_q.push_back(best);
            end
        end
    endfunction

    //////////////////////////////////////////////////
    // frame contents
    //////////////////////////////////////////////////

    // scrambled ramp, exponent outranks mantissa
    function automatic void fill_ramp();
        int k;
        for (int p = 0; p < frame_pixels; p++) begin
            k = (p * 37) % frame_pixels;
            frame[p].raw = {1'b0, 8'(124 + k / 16), 23'((15 - k % 16) << 19)};
        end
    endfunction

    // mostly negative, zeros of both signs, a few positives
    function automatic void fill_mixed();
        int k;
        for (int p = 0; p < frame_pixels; p++) begin
            k = (p * 29) % frame_pixels;
            case (k % 6)
                0: frame[p].raw = 32'h0000_0000;
                1: frame[p].raw = 32'h8000_0000;
                5: frame[p].raw = (k > 60) ? {1'b0, 8'(100 + k % 8), 23'(k << 10)}
                                           : {1'b1, 8'(118 + k % 8), 23'(k << 10)};
                default: frame[p].raw = {1'b1, 8'(120 + k % 8), 23'(k << 12)};
            endcase
        end
    endfunction

    // inf and nan exponents pulled down one step
    function automatic void fill_random();
        pool_fp_pkg::fp_word_t w;
        for (int p = 0; p < frame_pixels; p++) begin
            w.raw = rand_bits(32);
            if (w.fields.exponent == 8'hff) begin
                w.fields.exponent = 8'hfe;
            end
            frame[p] = w;
        end
    endfunction

    //////////////////////////////////////////////////
    // drive and collect
    //////////////////////////////////////////////////

    task automatic send_pixels(input int count, input bit gaps);
        int gap;
        for (int p = 0; p < count; p++) begin
            pixel       = frame[p];
            pixel_valid = 1'b1;
            frame_start = (p == 0);
            @(posedge clk);
            #drive_delay;
            pixel_valid = 1'b0;
            frame_start = 1'b0;
            if (gaps) begin
                gap = (rand_bits(2) % 3) + 1;
                repeat (gap) @(posedge clk);
                #drive_delay;
            end
        end
    endtask

    // sampled mid cycle
    always @(negedge clk) begin
        if (reset && pool_valid) begin
            err_count++;
            $display("Fail at %0t ns: pool_valid high during reset", $time);
        end else if (pool_valid === 1'b1) begin
            got_q.push_back(pool_out);
        end
    end

    task automatic compare_word(input string what, input pool_fp_pkg::fp_word_t got,
                                input pool_fp_pkg::fp_word_t want);
        check_count++;
        if (got.raw !== want.raw) begin
            err_count++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got.raw, want.raw);
        end
    endtask

    task automatic compare_count(input int got, input int want);
        check_count++;
        if (got != want) begin
            err_count++;
            $display("Fail at %0t ns: %0d results, expected %0d", $time, got, want);
        end
    endtask

    task automatic check_results();
        int waited = 0;
        while (got_q.size() < exp_q.size() && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        // room for any stray pulse
        repeat (extra_cycles) @(posedge clk);
        #drive_delay;
        compare_count(got_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            compare_word($sformatf("result %0d", i), got_q[i], exp_q[i]);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, err_count - errs_before);
        end
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic run_frame(input string name);
        int errs_before;
        errs_before = err_count;
        build_expected();
        send_pixels(frame_pixels, 1'b0);
        check_results();
        end_test(name, errs_before);
    endtask

    // gapped stream must repeat the dense results
    task automatic test_gaps();
        int errs_before;
        errs_before = err_count;
        fill_random();
        build_expected();
        send_pixels(frame_pixels, 1'b0);
        check_results();
        build_expected();
        send_pixels(frame_pixels, 1'b1);
        check_results();
        end_test("gaps", errs_before);
    endtask

    // reset lands with windows in flight
    task automatic test_reset();
        int errs_before;
        errs_before = err_count;
        fill_random();
        send_pixels(40, 1'b0);
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        got_q.delete();
        fill_ramp();
        build_expected();
        send_pixels(frame_pixels, 1'b0);
        check_results();
        end_test("reset", errs_before);
    endtask

    task automatic test_back_to_back();
        int errs_before;
        errs_before = err_count;
        // aborted frame leaves the counters mid row
        send_pixels(partial_pixels, 1'b0);
        fill_ramp();
        build_expected();
        send_pixels(frame_pixels, 1'b0);
        fill_random();
        build_expected();
        send_pixels(frame_pixels, 1'b0);
        check_results();
        end_test("back to back", errs_before);
    endtask

    initial begin
        reset       = 1'b1;
        pixel       = '0;
        pixel_valid = 1'b0;
        frame_start = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        fill_ramp();
        run_frame("ramp");
        fill_mixed();
        run_frame("mixed sign");
        fill_random();
        run_frame("random");
        test_gaps();
        test_reset();
        test_back_to_back();

        total_errs = err_count + dut.u_assert.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, check_count, err_count, dut.u_assert.fail_count);
        if (total_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // run length bound
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", watchdog_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
